//--- verilog/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// bits per spi frame
`define SPI_FRAME_BITS 8
// data lanes, quad capable
`define SPI_LANES 4
// flops on each async pin
`define SPI_SYNC_STAGES 2
// saturating error counter width
`define SPI_ERR_CNT_BITS 8

`endif

//--- verilog/spi_types_pkg.sv
package spi_types_pkg;

  // ----------------------------------------
  // frame controller states
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SHIFT = 2'd1,
    DONE  = 2'd2
  } frame_state_t;

  // ----------------------------------------
  // lane width, picked at frame start
  // ----------------------------------------
  typedef enum logic {
    LANE_SINGLE = 1'b0,
    LANE_QUAD   = 1'b1
  } lane_mode_t;

endpackage : spi_types_pkg

//--- verilog/spi_status_pkg.sv
package spi_status_pkg;

  // ----------------------------------------
  // protocol monitor error codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    // nothing seen yet
    ERR_NONE     = 2'd0,
    // mosi moved while spi_clk high
    ERR_UNSTABLE = 2'd1,
    // cs_n released mid frame
    ERR_ABORT    = 2'd2
  } spi_err_t;

  // code 3 unused, left for a future check

endpackage : spi_status_pkg

//--- verilog/spi_pin_sync.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_pin_sync (
  input  logic                  sclk,
  input  logic                  reset,
  input  logic                  spi_clk,
  input  logic                  cs_n,
  input  logic [`SPI_LANES-1:0] mosi,
  output logic                  clk_lvl,
  output logic                  clk_rise,
  output logic                  clk_fall,
  output logic                  sel,
  output logic                  cs_fall,
  output logic                  cs_rise,
  output logic [`SPI_LANES-1:0] mosi_s
);

  // pin vector layout: {mosi, cs_n, spi_clk}
  localparam int PW = `SPI_LANES + 2;
  // idle levels, clock low and slave deselected
  localparam logic [PW-1:0] PIN_IDLE = {{`SPI_LANES{1'b0}}, 1'b1, 1'b0};

  logic [PW-1:0] pin_raw;
  logic [PW-1:0] sync_q [`SPI_SYNC_STAGES];
  logic [PW-1:0] pin_q;
  logic [PW-1:0] pin_s;

  assign pin_raw = {mosi, cs_n, spi_clk};
  assign pin_s   = sync_q[`SPI_SYNC_STAGES-1];

  // ----------------------------------------
  // sync chain plus edge stage
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
        sync_q[i] <= PIN_IDLE;
      end
      pin_q    <= PIN_IDLE;
      clk_rise <= 1'b0;
      clk_fall <= 1'b0;
      cs_fall  <= 1'b0;
      cs_rise  <= 1'b0;
    end else begin
      sync_q[0] <= pin_raw;
      for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      // previous level, pulses line up with it
      pin_q    <= pin_s;
      clk_rise <= pin_s[0] & ~pin_q[0];
      clk_fall <= ~pin_s[0] & pin_q[0];
      cs_fall  <= ~pin_s[1] & pin_q[1];
      cs_rise  <= pin_s[1] & ~pin_q[1];
    end
  end

  // levels taken after the edge stage
  assign clk_lvl = pin_q[0];
  assign sel     = ~pin_q[1];
  assign mosi_s  = pin_q[PW-1:2];

endmodule : spi_pin_sync

//--- verilog/spi_frame_ctrl.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_frame_ctrl import spi_types_pkg::*; (
  input  logic       sclk,
  input  logic       reset,
  input  logic       sel,
  input  logic       cs_fall,
  input  logic       cs_rise,
  input  logic       clk_rise,
  input  logic       clk_fall,
  input  logic       lane_quad,
  output lane_mode_t lane_mode,
  output logic       frame_start,
  output logic       sample_en,
  output logic       shift_en,
  output logic       frame_last,
  output logic       frame_open
);

  localparam int CNT_W       = $clog2(`SPI_FRAME_BITS);
  // index of final sample per mode
  localparam int SINGLE_LAST = `SPI_FRAME_BITS - 1;
  localparam int QUAD_LAST   = `SPI_FRAME_BITS / `SPI_LANES - 1;

  frame_state_t     state;
  frame_state_t     state_nxt;
  logic [CNT_W-1:0] bit_cnt;
  logic [CNT_W-1:0] last_idx;
  logic             in_shift;

  // ----------------------------------------
  // strobes to the datapath
  // ----------------------------------------
  assign in_shift   = (state == SHIFT);
  assign last_idx   = (lane_mode == LANE_QUAD) ? CNT_W'(QUAD_LAST) : CNT_W'(SINGLE_LAST);
  assign sample_en  = in_shift && clk_rise;
  assign frame_last = sample_en && (bit_cnt == last_idx);
  // count zero means no sample yet in this frame,
  // so the falling edge belongs to the previous frame's last bit
  assign shift_en   = in_shift && clk_fall && (bit_cnt != '0);
  // first frame on select, later ones back to back
  assign frame_start = ((state == IDLE) && cs_fall) ||
                       ((state == DONE) && sel && !cs_rise);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (cs_fall) state_nxt = SHIFT;
      SHIFT:   if (frame_last) state_nxt = DONE;
      DONE:    state_nxt = sel ? SHIFT : IDLE;
      default: state_nxt = IDLE;
    endcase
    // deselect wins from anywhere
    if (cs_rise) begin
      state_nxt = IDLE;
    end
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      state      <= IDLE;
      bit_cnt    <= '0;
      frame_open <= 1'b0;
      lane_mode  <= LANE_SINGLE;
    end else begin
      state <= state_nxt;
      // sample counter
      if (cs_rise || frame_start) begin
        bit_cnt <= '0;
      end else if (sample_en) begin
        bit_cnt <= frame_last ? '0 : bit_cnt + 1'b1;
      end
      // open from first sample to completion
      if (cs_rise) begin
        frame_open <= 1'b0;
      end else if (sample_en) begin
        frame_open <= !frame_last;
      end
      // lane width held for the whole frame
      if (frame_start) begin
        lane_mode <= lane_quad ? LANE_QUAD : LANE_SINGLE;
      end
    end
  end

endmodule : spi_frame_ctrl

//--- verilog/spi_shift_datapath.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_shift_datapath import spi_types_pkg::*; (
  input  logic                       sclk,
  input  logic                       reset,
  input  lane_mode_t                 lane_mode,
  input  logic                       frame_start,
  input  logic                       sample_en,
  input  logic                       shift_en,
  input  logic                       frame_last,
  input  logic                       sel,
  input  logic [`SPI_LANES-1:0]      mosi_s,
  input  logic [`SPI_FRAME_BITS-1:0] tx_data,
  output logic [`SPI_FRAME_BITS-1:0] rx_data,
  output logic                       rx_valid,
  output logic [`SPI_LANES-1:0]      miso,
  output logic                       miso_en
);

  localparam int FB = `SPI_FRAME_BITS;
  localparam int LN = `SPI_LANES;

  logic [FB-1:0] rx_shift;
  logic [FB-1:0] rx_next;
  logic [FB-1:0] tx_shift;
  logic          quad;

  assign quad = (lane_mode == LANE_QUAD);

  // ----------------------------------------
  // receive side
  // ----------------------------------------
  // msb first, lane 3 is the high bit of a nibble
  always_comb begin
    if (quad) begin
      rx_next = {rx_shift[FB-LN-1:0], mosi_s};
    end else begin
      rx_next = {rx_shift[FB-2:0], mosi_s[0]};
    end
  end

  always_ff @(posedge sclk) begin
    if (sample_en) begin
      rx_shift <= rx_next;
    end
    // take the completed word, last bits included
    if (frame_last) begin
      rx_data <= rx_next;
    end
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= frame_last;
    end
  end

  // ----------------------------------------
  // transmit side
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (frame_start) begin
      tx_shift <= tx_data;
    end else if (shift_en) begin
      if (quad) begin
        tx_shift <= {tx_shift[FB-LN-1:0], {LN{1'b0}}};
      end else begin
        tx_shift <= {tx_shift[FB-2:0], 1'b0};
      end
    end
  end

  // top nibble or top bit, quiet when deselected
  always_comb begin
    if (!sel) begin
      miso = '0;
    end else if (quad) begin
      miso = tx_shift[FB-1 -: LN];
    end else begin
      miso = {{(LN-1){1'b0}}, tx_shift[FB-1]};
    end
  end

  assign miso_en = sel;

endmodule : spi_shift_datapath

//--- verilog/spi_protocol_monitor.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_protocol_monitor import spi_status_pkg::*; (
  input  logic                         sclk,
  input  logic                         reset,
  input  logic                         clk_lvl,
  input  logic                         clk_rise,
  input  logic [`SPI_LANES-1:0]        mosi_s,
  input  logic                         cs_rise,
  input  logic                         frame_open,
  output logic                         err_valid,
  output spi_err_t                     err_code,
  output logic [`SPI_ERR_CNT_BITS-1:0] err_count
);

  logic [`SPI_LANES-1:0] mosi_cap;
  logic                  unstable_seen;
  logic                  unstable_hit;
  logic                  abort_hit;
  logic                  err_hit;

  // ----------------------------------------
  // violation detect
  // ----------------------------------------
  // released before the frame finished
  assign abort_hit    = cs_rise && frame_open;
  // mosi moved after the sampling edge, one report per high phase
  assign unstable_hit = clk_lvl && !clk_rise && !unstable_seen &&
                        (mosi_s != mosi_cap);
  assign err_hit      = abort_hit || unstable_hit;

  // value the slave sampled
  always_ff @(posedge sclk) begin
    if (clk_rise) begin
      mosi_cap <= mosi_s;
    end
  end

  // ----------------------------------------
  // status outputs
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      unstable_seen <= 1'b0;
      err_valid     <= 1'b0;
      err_code      <= ERR_NONE;
      err_count     <= '0;
    end else begin
      // rearm on each new high phase
      if (clk_rise) begin
        unstable_seen <= 1'b0;
      end else if (unstable_hit) begin
        unstable_seen <= 1'b1;
      end
      err_valid <= err_hit;
      // abort has priority, code holds until next error
      if (abort_hit) begin
        err_code <= ERR_ABORT;
      end else if (unstable_hit) begin
        err_code <= ERR_UNSTABLE;
      end
      // saturate at all ones
      if (err_hit && (err_count != '1)) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

endmodule : spi_protocol_monitor

//--- verilog/spi_slave_top.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_slave_top import spi_types_pkg::*, spi_status_pkg::*; (
  input  logic                         sclk,
  input  logic                         reset,
  input  logic                         spi_clk,
  input  logic                         cs_n,
  input  logic [`SPI_LANES-1:0]        mosi,
  input  logic                         lane_quad,
  input  logic [`SPI_FRAME_BITS-1:0]   tx_data,
  output logic [`SPI_LANES-1:0]        miso,
  output logic                         miso_en,
  output logic [`SPI_FRAME_BITS-1:0]   rx_data,
  output logic                         rx_valid,
  output logic                         err_valid,
  output spi_err_t                     err_code,
  output logic [`SPI_ERR_CNT_BITS-1:0] err_count
);

  // synchronized pins and edges
  logic                  clk_lvl;
  logic                  clk_rise;
  logic                  clk_fall;
  logic                  sel;
  logic                  cs_fall;
  logic                  cs_rise;
  logic [`SPI_LANES-1:0] mosi_s;

  // frame strobes
  lane_mode_t lane_mode;
  logic       frame_start;
  logic       sample_en;
  logic       shift_en;
  logic       frame_last;
  logic       frame_open;

  // ----------------------------------------
  // pin capture
  // ----------------------------------------
  spi_pin_sync u_sync (
    .sclk     (sclk),
    .reset    (reset),
    .spi_clk  (spi_clk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .clk_lvl  (clk_lvl),
    .clk_rise (clk_rise),
    .clk_fall (clk_fall),
    .sel      (sel),
    .cs_fall  (cs_fall),
    .cs_rise  (cs_rise),
    .mosi_s   (mosi_s)
  );

  // ----------------------------------------
  // framing
  // ----------------------------------------
  spi_frame_ctrl u_ctrl (
    .sclk        (sclk),
    .reset       (reset),
    .sel         (sel),
    .cs_fall     (cs_fall),
    .cs_rise     (cs_rise),
    .clk_rise    (clk_rise),
    .clk_fall    (clk_fall),
    .lane_quad   (lane_quad),
    .lane_mode   (lane_mode),
    .frame_start (frame_start),
    .sample_en   (sample_en),
    .shift_en    (shift_en),
    .frame_last  (frame_last),
    .frame_open  (frame_open)
  );

  // shift registers, both directions
  spi_shift_datapath u_dp (
    .sclk        (sclk),
    .reset       (reset),
    .lane_mode   (lane_mode),
    .frame_start (frame_start),
    .sample_en   (sample_en),
    .shift_en    (shift_en),
    .frame_last  (frame_last),
    .sel         (sel),
    .mosi_s      (mosi_s),
    .tx_data     (tx_data),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .miso        (miso),
    .miso_en     (miso_en)
  );

  // protocol checks
  spi_protocol_monitor u_mon (
    .sclk       (sclk),
    .reset      (reset),
    .clk_lvl    (clk_lvl),
    .clk_rise   (clk_rise),
    .mosi_s     (mosi_s),
    .cs_rise    (cs_rise),
    .frame_open (frame_open),
    .err_valid  (err_valid),
    .err_code   (err_code),
    .err_count  (err_count)
  );

endmodule : spi_slave_top

//--- verif/tb_spi_slave_tasks.svh
`ifndef TB_SPI_SLAVE_TASKS_SVH
`define TB_SPI_SLAVE_TASKS_SVH

// ----------------------------------------
// spi master, mode 0, msb first
// ----------------------------------------

// tx word and lane width go out with the select
task automatic open_select(input logic [FB-1:0] tx, input logic quad);
  tx_data      = tx;
  lane_quad    = quad;
  hi_lane_seen = 1'b0;
  en_low_seen  = 1'b0;
  spi_clk      = 1'b0;
  cs_n         = 1'b0;
  // slave loads its tx register well before the first rise
  repeat (HALF) @(negedge sclk);
endtask

// one frame, or a partial one when beats > 0
task automatic xfer_frame(
  input  logic [FB-1:0] data,
  input  logic          quad,
  input  int            beats,
  input  int            glitch,
  input  logic [FB-1:0] tx_next,
  input  logic          quad_next,
  output logic [FB-1:0] got
);
  int n;
  n   = (beats > 0) ? beats : (quad ? FB / LN : FB);
  got = '0;
  for (int i = 0; i < n; i++) begin
    // mosi moves together with the falling clock
    if (quad) begin
      mosi = data[FB-1-LN*i -: LN];
    end else begin
      mosi = {{(LN-1){1'b0}}, data[FB-1-i]};
    end
    spi_clk = 1'b0;
    repeat (HALF) @(negedge sclk);
    // miso taken just before the rise
    if (quad) begin
      got = {got[FB-LN-1:0], miso};
    end else begin
      got = {got[FB-2:0], miso[0]};
      if (miso[LN-1:1] != '0) begin
        hi_lane_seen = 1'b1;
      end
    end
    if (miso_en !== 1'b1) begin
      en_low_seen = 1'b1;
    end
    spi_clk = 1'b1;
    // settings for a back to back frame, picked up in DONE
    if (i == n - 1) begin
      tx_data   = tx_next;
      lane_quad = quad_next;
    end
    if (i == glitch) begin
      // flip lane 0 halfway through the high phase
      repeat (HALF / 2) @(negedge sclk);
      mosi[0] = ~mosi[0];
      repeat (HALF - HALF / 2) @(negedge sclk);
    end else begin
      repeat (HALF) @(negedge sclk);
    end
  end
  spi_clk = 1'b0;
endtask

// last fall settles, then deselect and idle
task automatic close_select(input int gap);
  repeat (HALF) @(negedge sclk);
  cs_n = 1'b1;
  mosi = '0;
  repeat (gap) @(negedge sclk);
endtask

`endif

//--- verif/tb_spi_slave.sv
`timescale 1ns/1ns
`include "spi_settings.svh"

module tb_spi_slave;

  localparam int FB      = `SPI_FRAME_BITS;
  localparam int LN      = `SPI_LANES;
  // spi half period in sclk cycles covers sync and edge stages with slack
  localparam int HALF    = `SPI_SYNC_STAGES + 4;
  localparam int GAP_MAX = 24;
  // frames and selects over all six tests
  localparam int N_FRAMES  = 109;
  localparam int N_SELECTS = 107;
  localparam int LIMIT     = N_FRAMES * FB * 2 * HALF +
                             N_SELECTS * (GAP_MAX + 4 * HALF) + 500;
  // monitor codes as the slave reports them
  localparam logic [1:0] CODE_UNSTABLE = 2'd1;
  localparam logic [1:0] CODE_ABORT    = 2'd2;

  logic                         sclk;
  logic                         reset;
  logic                         spi_clk;
  logic                         cs_n;
  logic [LN-1:0]                mosi;
  logic                         lane_quad;
  logic [FB-1:0]                tx_data;
  logic [LN-1:0]                miso;
  logic                         miso_en;
  logic [FB-1:0]                rx_data;
  logic                         rx_valid;
  logic                         err_valid;
  logic [1:0]                   err_code;
  logic [`SPI_ERR_CNT_BITS-1:0] err_count;

  // model and bookkeeping
  logic [31:0]   rng_state;
  logic [FB-1:0] rx_seen [$];
  logic [1:0]    err_seen [$];
  logic          hi_lane_seen;
  logic          en_low_seen;
  int            err_total  = 0;
  int            fails      = 0;
  int            fails_mark = 0;
  int            tests_run  = 0;
  int            cycles     = 0;

  `include "tb_spi_slave_tasks.svh"

  spi_slave_top dut0 (.*);

  initial sclk = 1'b0;
  always #5 sclk = ~sclk;

  // run limit from the frame count
  always @(posedge sclk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("run stopped after %0d cycles, the DUT stopped responding", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------
  // output capture sees flop values from before the edge
  // ----------------------------------------
  always @(posedge sclk) begin
    if (!reset && rx_valid) begin
      rx_seen.push_back(rx_data);
    end
    if (!reset && err_valid) begin
      err_seen.push_back(err_code);
    end
  end

  // lcg with numerical recipes constants
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [FB-1:0] rand_byte();
    logic [31:0] r;
    r = next_rand();
    return r[23:16];
  endfunction

  // idle gap 8 to 23 cycles
  function automatic int rand_gap();
    logic [31:0] r;
    r = next_rand();
    return 8 + r[27:24];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, act);
    fails++;
  endtask

  task automatic report_problem(input string what);
    $display("error at %0t ns: %s", $time, what);
    fails++;
  endtask

  // bounded poll of both capture queues
  task automatic wait_events(input int rx_n, input int err_n);
    int t;
    t = 0;
    while ((rx_seen.size() < rx_n || err_seen.size() < err_n) && t < 4 * HALF) begin
      @(negedge sclk);
      t++;
    end
    if (rx_seen.size() < rx_n) begin
      report_problem("rx_valid never pulsed for a completed frame");
    end
    if (err_seen.size() < err_n) begin
      report_problem("err_valid never pulsed for an injected violation");
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("%s done, %0d failures", name, fails - fails_mark);
    fails_mark = fails;
  endtask

  // one selected frame with rx and optional miso checks
  task automatic plain_frame(input logic quad, input logic check_tx);
    logic [FB-1:0] data;
    logic [FB-1:0] tx;
    logic [FB-1:0] got;
    int            base;
    data = rand_byte();
    tx   = rand_byte();
    base = rx_seen.size();
    open_select(tx, quad);
    xfer_frame(data, quad, 0, -1, tx, quad, got);
    close_select(rand_gap());
    wait_events(base + 1, 0);
    if (rx_seen.size() != base + 1) begin
      report_problem("wrong number of rx_valid pulses for one frame");
    end else if (rx_seen[base] !== data) begin
      report_mismatch("rx_data", data, rx_seen[base]);
    end
    if (check_tx && got !== tx) begin
      report_mismatch("miso", tx, got);
    end
    if (hi_lane_seen) begin
      report_problem("miso lanes 1 to 3 driven in single lane mode");
    end
    if (en_low_seen) begin
      report_problem("miso_en low while cs_n was low");
    end
    if (miso_en !== 1'b0) begin
      report_mismatch("miso_en", 1'b0, miso_en);
    end
    // all lanes quiet once deselected
    if (miso !== '0) begin
      report_mismatch("miso", 0, miso);
    end
    if (err_seen.size() != 0) begin
      report_problem("monitor flagged clean traffic");
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [FB-1:0] d [3];
    logic [FB-1:0] txw [4];
    logic          q [4];
    logic [FB-1:0] got;
    logic [31:0]   r;
    int            base_rx;
    int            base_err;

    rng_state = 32'hf26f_beae;
    reset     = 1'b1;
    spi_clk   = 1'b0;
    cs_n      = 1'b1;
    mosi      = '0;
    lane_quad = 1'b0;
    tx_data   = '0;
    repeat (3) @(negedge sclk);
    reset = 1'b0;
    repeat (2) @(negedge sclk);
    if (err_count !== '0) begin
      report_mismatch("err_count", 0, err_count);
    end

    for (int i = 0; i < 40; i++) begin
      plain_frame(1'b0, 1'b0);
    end
    end_test("single-lane receive");
    for (int i = 0; i < 40; i++) begin
      plain_frame(1'b1, 1'b1);
    end
    end_test("quad-lane receive and transmit");
    for (int i = 0; i < 20; i++) begin
      plain_frame(1'b0, 1'b1);
    end
    end_test("single-lane transmit");

    // three frames in one select with mixed lane widths
    base_rx = rx_seen.size();
    for (int i = 0; i < 4; i++) begin
      r      = next_rand();
      txw[i] = r[15:8];
      q[i]   = r[28];
    end
    open_select(txw[0], q[0]);
    for (int i = 0; i < 3; i++) begin
      d[i] = rand_byte();
      xfer_frame(d[i], q[i], 0, -1, txw[i+1], q[i+1], got);
      if (got !== txw[i]) begin
        report_mismatch("miso", txw[i], got);
      end
    end
    close_select(rand_gap());
    wait_events(base_rx + 3, 0);
    if (rx_seen.size() != base_rx + 3) begin
      report_problem("back to back frames gave the wrong rx_valid count");
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (rx_seen[base_rx+i] !== d[i]) begin
          report_mismatch("rx_data", d[i], rx_seen[base_rx+i]);
        end
      end
    end
    if (err_seen.size() != 0) begin
      report_problem("monitor flagged back to back traffic");
    end
    end_test("back-to-back frames");

    // deselect after 1 to 7 bits
    for (int i = 0; i < 3; i++) begin
      base_rx  = rx_seen.size();
      base_err = err_seen.size();
      r        = next_rand();
      open_select(r[15:8], 1'b0);
      xfer_frame(r[23:16], 1'b0, 1 + r[31:29] % 7, -1, r[15:8], 1'b0, got);
      close_select(rand_gap());
      err_total++;
      wait_events(base_rx, base_err + 1);
      if (rx_seen.size() != base_rx) begin
        report_problem("rx_valid pulsed for an aborted frame");
      end
      if (err_seen.size() > base_err && err_seen[base_err] !== CODE_ABORT) begin
        report_mismatch("err_code", CODE_ABORT, err_seen[base_err]);
      end
      if (err_count !== err_total) begin
        report_mismatch("err_count", err_total, err_count);
      end
    end
    end_test("abort");

    // lane 0 flips mid high phase after the rise sampled it
    for (int i = 0; i < 3; i++) begin
      base_rx  = rx_seen.size();
      base_err = err_seen.size();
      r        = next_rand();
      open_select(r[15:8], 1'b0);
      xfer_frame(r[23:16], 1'b0, 0, r[26:24], r[15:8], 1'b0, got);
      close_select(rand_gap());
      err_total++;
      wait_events(base_rx + 1, base_err + 1);
      if (rx_seen.size() > base_rx && rx_seen[base_rx] !== r[23:16]) begin
        report_mismatch("rx_data", r[23:16], rx_seen[base_rx]);
      end
      if (err_seen.size() > base_err + 1) begin
        report_problem("instability reported more than once");
      end
      if (err_seen.size() > base_err && err_seen[base_err] !== CODE_UNSTABLE) begin
        report_mismatch("err_code", CODE_UNSTABLE, err_seen[base_err]);
      end
      if (err_count !== err_total) begin
        report_mismatch("err_count", err_total, err_count);
      end
    end
    end_test("instability");

    $display("tests run: %0d, failures: %0d", tests_run, fails);
    if (fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_spi_slave

//--- verilog.f
+incdir+verilog
+incdir+verif
verilog/spi_types_pkg.sv
verilog/spi_status_pkg.sv
verilog/spi_pin_sync.sv
verilog/spi_frame_ctrl.sv
verilog/spi_shift_datapath.sv
verilog/spi_protocol_monitor.sv
verilog/spi_slave_top.sv
verif/tb_spi_slave.sv
